/* rtl/kbd_pkg.sv */
package kbd_pkg;

	// one byte from the keyboard, with its parity check result
	typedef struct packed {
		logic [7:0] code;
		logic       parity_err;
	} ps2_byte_t;

	// frame receiver
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_t;

	// make/break tracking
	typedef enum logic [1:0] {
		KEY_IDLE,
		KEY_HELD,
		KEY_BREAK_PENDING
	} key_state_t;

	// set 2 break prefix, the next byte is the released key
	localparam logic [7:0] BREAK_PREFIX = 8'hF0;

endpackage

/* rtl/disp_pkg.sv */
package disp_pkg;

	// one pixel slot from the timing generator
	typedef struct packed {
		logic [9:0] h;
		logic [9:0] v;
		logic       active;
	} pix_pos_t;

	// syncs are active low
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic blank_n;
	} sync_t;

	typedef enum logic [2:0] {
		GLYPH_NONE,
		GLYPH_Q,
		GLYPH_D,
		GLYPH_A,
		GLYPH_S
	} glyph_t;

	// indexed by glyph_t, then row; bit 7 is the leftmost pixel
	localparam logic [0:4][0:7][7:0] GLYPH_ROM = '{
		'{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
		'{8'h3C, 8'h66, 8'h66, 8'h66, 8'h76, 8'h3C, 8'h0E, 8'h00},
		'{8'h78, 8'h6C, 8'h66, 8'h66, 8'h66, 8'h6C, 8'h78, 8'h00},
		'{8'h18, 8'h3C, 8'h66, 8'h66, 8'h7E, 8'h66, 8'h66, 8'h00},
		'{8'h3C, 8'h66, 8'h60, 8'h3C, 8'h06, 8'h66, 8'h3C, 8'h00}
	};

	// segments a..g in bits 7..1, dp in bit 0, active high
	localparam logic [0:15][7:0] SEG_HEX = '{
		8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66, 8'hB6, 8'hBE, 8'hE0,
		8'hFE, 8'hF6, 8'hEE, 8'h3E, 8'h9C, 8'h7A, 8'h9E, 8'h8E
	};

endpackage

/* rtl/ps2_receiver.sv */
`timescale 1ns/1ns

module ps2_receiver (
	input  logic               clk,
	input  logic               rst,
	input  logic               ps2_clk,
	input  logic               ps2_data,
	output logic               byte_valid,
	output kbd_pkg::ps2_byte_t rx_byte,
	output logic               busy,
	output logic               frame_err
);

	logic [1:0] clk_sync;
	logic [1:0] data_sync;
	logic       clk_d;
	logic       fall;
	logic       bit_in;

	kbd_pkg::rx_state_t state;
	logic [2:0]         bit_cnt;
	logic [7:0]         shift;
	logic               par_bit;

	// two-flop synchronizers, then a registered falling-edge detect
	always_ff @(posedge clk) begin
		if (rst) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_d     <= 1'b1;
			fall      <= 1'b0;
			bit_in    <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_d     <= clk_sync[1];
			fall      <= clk_d & ~clk_sync[1];
			bit_in    <= data_sync[1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= kbd_pkg::RX_IDLE;
			bit_cnt    <= 3'd0;
			byte_valid <= 1'b0;
			frame_err  <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			frame_err  <= 1'b0;
			if (fall) begin
				case (state)
				kbd_pkg::RX_IDLE: begin
					// start bit must be low
					if (!bit_in) begin
						state   <= kbd_pkg::RX_DATA;
						bit_cnt <= 3'd0;
					end else begin
						frame_err <= 1'b1;
					end
				end
				kbd_pkg::RX_DATA: begin
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7) begin
						state <= kbd_pkg::RX_PARITY;
					end
				end
				kbd_pkg::RX_PARITY: begin
					state <= kbd_pkg::RX_STOP;
				end
				default: begin
					// stop bit high, else the frame is dropped
					byte_valid <= bit_in;
					frame_err  <= ~bit_in;
					state      <= kbd_pkg::RX_IDLE;
				end
				endcase
			end
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge clk) begin
		if (fall) begin
			if (state == kbd_pkg::RX_DATA) begin
				shift <= {bit_in, shift[7:1]};
			end
			if (state == kbd_pkg::RX_PARITY) begin
				par_bit <= bit_in;
			end
			if (state == kbd_pkg::RX_STOP) begin
				rx_byte.code       <= shift;
				rx_byte.parity_err <= ~^{shift, par_bit};
			end
		end
	end

	assign busy = (state != kbd_pkg::RX_IDLE);

	a_valid_single: assert property (@(posedge clk) disable iff (rst)
		byte_valid |=> !byte_valid);

	a_valid_idle: assert property (@(posedge clk) disable iff (rst)
		byte_valid |-> !busy);

endmodule

/* rtl/key_event_fsm.sv */
`timescale 1ns/1ns

module key_event_fsm (
	input  logic               clk,
	input  logic               rst,
	input  logic               byte_valid,
	input  kbd_pkg::ps2_byte_t rx_byte,
	output logic [7:0]         key_code,
	output logic [7:0]         rel_count,
	output logic               key_held
);

	kbd_pkg::key_state_t state;

	// bytes with bad parity are ignored
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= kbd_pkg::KEY_IDLE;
			key_code  <= 8'h00;
			rel_count <= 8'd0;
		end else if (byte_valid && !rx_byte.parity_err) begin
			case (state)
			kbd_pkg::KEY_BREAK_PENDING: begin
				// released key code itself is not checked
				key_code  <= 8'h00;
				rel_count <= rel_count + 8'd1;
				state     <= kbd_pkg::KEY_IDLE;
			end
			default: begin
				if (rx_byte.code == kbd_pkg::BREAK_PREFIX) begin
					state <= kbd_pkg::KEY_BREAK_PENDING;
				end else begin
					key_code <= rx_byte.code;
					state    <= kbd_pkg::KEY_HELD;
				end
			end
			endcase
		end
	end

	assign key_held = (state == kbd_pkg::KEY_HELD);

	a_idle_clear: assert property (@(posedge clk) disable iff (rst)
		(state == kbd_pkg::KEY_IDLE) |-> (key_code == 8'h00));

endmodule

/* rtl/vga_timing.sv */
`timescale 1ns/1ns

module vga_timing #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33
) (
	input  logic             clk,
	input  logic             rst,
	output disp_pkg::pix_pos_t pos,
	output disp_pkg::sync_t    sync
);

	localparam logic [9:0] H_VIS   = 10'(H_ACTIVE);
	localparam logic [9:0] HS_BEG  = 10'(H_ACTIVE + H_FRONT);
	localparam logic [9:0] HS_END  = 10'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam logic [9:0] H_TOTAL = 10'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK);
	localparam logic [9:0] V_VIS   = 10'(V_ACTIVE);
	localparam logic [9:0] VS_BEG  = 10'(V_ACTIVE + V_FRONT);
	localparam logic [9:0] VS_END  = 10'(V_ACTIVE + V_FRONT + V_SYNC);
	localparam logic [9:0] V_TOTAL = 10'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK);

	logic [9:0] h_cnt;
	logic [9:0] v_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			h_cnt <= 10'd0;
			v_cnt <= 10'd0;
		end else if (h_cnt == H_TOTAL - 10'd1) begin
			h_cnt <= 10'd0;
			v_cnt <= (v_cnt == V_TOTAL - 10'd1) ? 10'd0 : v_cnt + 10'd1;
		end else begin
			h_cnt <= h_cnt + 10'd1;
		end
	end

	assign pos.h      = h_cnt;
	assign pos.v      = v_cnt;
	assign pos.active = (h_cnt < H_VIS) && (v_cnt < V_VIS);

	// low inside the pulse window
	assign sync.hsync   = ~((h_cnt >= HS_BEG) && (h_cnt < HS_END));
	assign sync.vsync   = ~((v_cnt >= VS_BEG) && (v_cnt < VS_END));
	assign sync.blank_n = pos.active;

	a_h_range: assert property (@(posedge clk) disable iff (rst)
		h_cnt < H_TOTAL);

endmodule

/* rtl/glyph_renderer.sv */
`timescale 1ns/1ns

module glyph_renderer #(
	parameter int GLYPH_SCALE = 4,
	parameter int H_ACTIVE    = 640
) (
	input  logic               clk,
	input  logic               rst,
	input  disp_pkg::pix_pos_t pos,
	input  disp_pkg::sync_t    sync_in,
	input  logic [7:0]         key_code,
	output logic [23:0]        rgb,
	output disp_pkg::sync_t    sync_out
);

	localparam logic [9:0] SCALE = 10'(GLYPH_SCALE);
	localparam logic [9:0] BOX   = 10'(8 * GLYPH_SCALE);

	disp_pkg::glyph_t glyph;
	logic [9:0]       row_full;
	logic [9:0]       col_full;
	logic [7:0]       row_bits;
	logic             in_box;
	logic             ink;

	// scan code to glyph
	always_comb begin
		case (key_code)
		8'h15:   glyph = disp_pkg::GLYPH_Q;
		8'h23:   glyph = disp_pkg::GLYPH_D;
		8'h1C:   glyph = disp_pkg::GLYPH_A;
		8'h1B:   glyph = disp_pkg::GLYPH_S;
		default: glyph = disp_pkg::GLYPH_NONE;
		endcase
	end

	// each bitmap pixel covers a SCALE x SCALE block
	assign row_full = pos.v / SCALE;
	assign col_full = pos.h / SCALE;
	assign in_box   = pos.active && (pos.h < BOX) && (pos.v < BOX);
	assign row_bits = disp_pkg::GLYPH_ROM[glyph][row_full[2:0]];
	assign ink      = in_box && row_bits[3'd7 - col_full[2:0]];

	// colour and sync leave together
	always_ff @(posedge clk) begin
		if (rst) begin
			rgb      <= 24'hFFFFFF;
			sync_out <= '{hsync: 1'b1, vsync: 1'b1, blank_n: 1'b0};
		end else begin
			rgb      <= ink ? 24'h000000 : 24'hFFFFFF;
			sync_out <= sync_in;
		end
	end

	a_box_fits: assert property (@(posedge clk)
		(8 * GLYPH_SCALE) <= H_ACTIVE);

endmodule

/* rtl/seg_display.sv */
`timescale 1ns/1ns

module seg_display (
	input  logic [7:0] key_code,
	input  logic [7:0] rel_count,
	output logic [7:0] seg0,
	output logic [7:0] seg1,
	output logic [7:0] seg4,
	output logic [7:0] seg5
);

	// board digits are active low
	function automatic logic [7:0] hex_seg(input logic [3:0] nib);
		return ~disp_pkg::SEG_HEX[nib];
	endfunction

	// key code on the right pair
	assign seg0 = hex_seg(key_code[3:0]);
	assign seg1 = hex_seg(key_code[7:4]);

	// release count on the left pair
	assign seg4 = hex_seg(rel_count[3:0]);
	assign seg5 = hex_seg(rel_count[7:4]);

endmodule

/* rtl/kbd_vga_top.sv */
`timescale 1ns/1ns

module kbd_vga_top #(
	parameter int H_ACTIVE    = 640,
	parameter int H_FRONT     = 16,
	parameter int H_SYNC      = 96,
	parameter int H_BACK      = 48,
	parameter int V_ACTIVE    = 480,
	parameter int V_FRONT     = 10,
	parameter int V_SYNC      = 2,
	parameter int V_BACK      = 33,
	parameter int GLYPH_SCALE = 4
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        ps2_clk,
	input  logic        ps2_data,
	output logic [15:0] ledr,
	output logic        vga_hsync,
	output logic        vga_vsync,
	output logic        vga_blank_n,
	output logic [7:0]  vga_r,
	output logic [7:0]  vga_g,
	output logic [7:0]  vga_b,
	output logic [7:0]  seg0,
	output logic [7:0]  seg1,
	output logic [7:0]  seg4,
	output logic [7:0]  seg5
);

	kbd_pkg::ps2_byte_t rx_byte;
	logic               byte_valid;
	logic               busy;
	logic               frame_err;
	logic [7:0]         key_code;
	logic [7:0]         rel_count;
	logic               key_held;
	logic               err_sticky;
	disp_pkg::pix_pos_t pos;
	disp_pkg::sync_t    sync_raw;
	disp_pkg::sync_t    sync_vid;
	logic [23:0]        rgb;

	ps2_receiver ps2_receiver_i (
		.clk        (clk),
		.rst        (rst),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.byte_valid (byte_valid),
		.rx_byte    (rx_byte),
		.busy       (busy),
		.frame_err  (frame_err)
	);

	key_event_fsm key_event_fsm_i (
		.clk        (clk),
		.rst        (rst),
		.byte_valid (byte_valid),
		.rx_byte    (rx_byte),
		.key_code   (key_code),
		.rel_count  (rel_count),
		.key_held   (key_held)
	);

	vga_timing #(
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_SYNC   (H_SYNC),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_SYNC   (V_SYNC),
		.V_BACK   (V_BACK)
	) vga_timing_i (
		.clk  (clk),
		.rst  (rst),
		.pos  (pos),
		.sync (sync_raw)
	);

	glyph_renderer #(
		.GLYPH_SCALE (GLYPH_SCALE),
		.H_ACTIVE    (H_ACTIVE)
	) glyph_renderer_i (
		.clk      (clk),
		.rst      (rst),
		.pos      (pos),
		.sync_in  (sync_raw),
		.key_code (key_code),
		.rgb      (rgb),
		.sync_out (sync_vid)
	);

	seg_display seg_display_i (
		.key_code  (key_code),
		.rel_count (rel_count),
		.seg0      (seg0),
		.seg1      (seg1),
		.seg4      (seg4),
		.seg5      (seg5)
	);

	// any bad frame lights the error led until reset
	always_ff @(posedge clk) begin
		if (rst) begin
			err_sticky <= 1'b0;
		end else if (frame_err || (byte_valid && rx_byte.parity_err)) begin
			err_sticky <= 1'b1;
		end
	end

	assign ledr = {key_code, 4'b0000, key_held, busy, err_sticky, byte_valid};

	assign vga_hsync   = sync_vid.hsync;
	assign vga_vsync   = sync_vid.vsync;
	assign vga_blank_n = sync_vid.blank_n;
	assign vga_r       = rgb[23:16];
	assign vga_g       = rgb[15:8];
	assign vga_b       = rgb[7:0];

	a_err_sticky: assert property (@(posedge clk) disable iff (rst)
		ledr[1] |=> ledr[1]);

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 4
) (
	output logic clk
);

	initial clk = 1'b0;

	// free running, 50% duty
	always #(PERIOD / 2) clk = ~clk;

endmodule

/* testbench/kbd_vga_tb.sv */
`timescale 1ns/1ns

module kbd_vga_tb;

	localparam int CLK_PERIOD  = 4;
	localparam int PS2_PERIOD  = 40;
	localparam int H_ACTIVE    = 64;
	localparam int H_FRONT     = 4;
	localparam int H_SYNC      = 4;
	localparam int H_BACK      = 4;
	localparam int V_ACTIVE    = 48;
	localparam int V_FRONT     = 4;
	localparam int V_SYNC      = 4;
	localparam int V_BACK      = 4;
	localparam int GLYPH_SCALE = 2;
	localparam int H_TOTAL     = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL     = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int FRAME       = H_TOTAL * V_TOTAL;

	// segments a..g then dp, active high
	localparam logic [7:0] SEG_REF [16] = '{
		8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66, 8'hB6, 8'hBE, 8'hE0,
		8'hFE, 8'hF6, 8'hEE, 8'h3E, 8'h9C, 8'h7A, 8'h9E, 8'h8E
	};

	logic        clk;
	logic        rst      = 1'b1;
	logic        ps2_clk  = 1'b1;
	logic        ps2_data = 1'b1;
	logic [15:0] ledr;
	logic        vga_hsync;
	logic        vga_vsync;
	logic        vga_blank_n;
	logic [7:0]  vga_r;
	logic [7:0]  vga_g;
	logic [7:0]  vga_b;
	logic [7:0]  seg0;
	logic [7:0]  seg1;
	logic [7:0]  seg4;
	logic [7:0]  seg5;

	logic [7:0]  tr_byte [$];
	int          tr_bad [$];
	logic [7:0]  tr_code [$];
	logic [7:0]  tr_count [$];
	logic [63:0] tr_glyph [$];
	int          n_steps   = 0;
	int          step_errs = 0;
	int          seed      = 8;
	int          strobes   = 0;

	tb_clock #(.PERIOD(CLK_PERIOD)) tb_clock_i (.clk(clk));

	kbd_vga_top #(
		.H_ACTIVE    (H_ACTIVE),
		.H_FRONT     (H_FRONT),
		.H_SYNC      (H_SYNC),
		.H_BACK      (H_BACK),
		.V_ACTIVE    (V_ACTIVE),
		.V_FRONT     (V_FRONT),
		.V_SYNC      (V_SYNC),
		.V_BACK      (V_BACK),
		.GLYPH_SCALE (GLYPH_SCALE)
	) kbd_vga_top_i (
		.clk         (clk),
		.rst         (rst),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data),
		.ledr        (ledr),
		.vga_hsync   (vga_hsync),
		.vga_vsync   (vga_vsync),
		.vga_blank_n (vga_blank_n),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b),
		.seg0        (seg0),
		.seg1        (seg1),
		.seg4        (seg4),
		.seg5        (seg5)
	);

	// byte strobes seen on ledr[0]
	always @(negedge clk) begin
		if (ledr[0]) begin
			strobes++;
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic note_mismatch(input string msg);
		$display("Fail at %0t: %s", $time, msg);
		step_errs++;
	endtask

	// start, 8 data bits lsb first, odd parity, stop; data moves while ps2_clk is high
	task automatic send_frame(input logic [7:0] data, input int bad);
		logic [10:0] bits;
		logic        par;
		par = ~^data;
		if (bad == 1) begin
			par = ~par;
		end
		bits = {(bad == 2) ? 1'b0 : 1'b1, par, data, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(posedge clk);
			ps2_data <= bits[i];
			wait_cycles(PS2_PERIOD / 4);
			ps2_clk <= 1'b0;
			wait_cycles(PS2_PERIOD / 2);
			ps2_clk <= 1'b1;
			wait_cycles(PS2_PERIOD / 4 - 1);
		end
		@(posedge clk);
		ps2_data <= 1'b1;
	endtask

	// busy must stay low for 10 cycles in a row
	task automatic wait_idle(output logic ok);
		int quiet;
		int spent;
		quiet = 0;
		spent = 0;
		while (quiet < 10 && spent < 400) begin
			@(negedge clk);
			quiet = ledr[2] ? 0 : quiet + 1;
			spent++;
		end
		ok = (quiet >= 10);
	endtask

	// row 0 sits in the top byte of the bitmap, leftmost pixel first
	function automatic logic [23:0] pixel_ref(input logic [63:0] bitmap, input int x,
			input int y);
		int r;
		int c;
		if (x >= 8 * GLYPH_SCALE || y >= 8 * GLYPH_SCALE) begin
			return 24'hFFFFFF;
		end
		r = y / GLYPH_SCALE;
		c = x / GLYPH_SCALE;
		return bitmap[63 - 8 * r - c] ? 24'h000000 : 24'hFFFFFF;
	endfunction

	// one frame, from one vsync fall to the next
	task automatic check_frame(input logic [63:0] bitmap);
		logic hs_q;
		logic vs_q;
		logic bl_q;
		logic done;
		int   hs_pulses;
		int   hs_len;
		int   bad_len;
		int   vs_low;
		int   bad_pix;
		int   x;
		int   y;
		@(negedge clk);
		vs_q = vga_vsync;
		@(negedge clk);
		while (!(vs_q && !vga_vsync)) begin
			vs_q = vga_vsync;
			@(negedge clk);
		end
		hs_q      = vga_hsync;
		vs_q      = vga_vsync;
		bl_q      = vga_blank_n;
		done      = 1'b0;
		hs_pulses = 0;
		hs_len    = 0;
		bad_len   = 0;
		vs_low    = 1;
		bad_pix   = 0;
		x         = 0;
		y         = -1;
		while (!done) begin
			@(negedge clk);
			if (vs_q && !vga_vsync) begin
				done = 1'b1;
			end else begin
				if (!vga_hsync) begin
					if (hs_q) begin
						hs_pulses++;
						hs_len = 0;
					end
					hs_len++;
				end else if (!hs_q && hs_len != H_SYNC) begin
					bad_len++;
				end
				if (!vga_vsync) begin
					vs_low++;
				end
				if (vga_blank_n && !bl_q) begin
					y++;
					x = 0;
				end
				if (vga_blank_n) begin
					if ({vga_r, vga_g, vga_b} != pixel_ref(bitmap, x, y)) begin
						bad_pix++;
					end
					x++;
				end
			end
			hs_q = vga_hsync;
			vs_q = vga_vsync;
			bl_q = vga_blank_n;
		end
		assert (hs_pulses == V_TOTAL) else
			note_mismatch($sformatf("%0d hsync pulses, expected %0d", hs_pulses, V_TOTAL));
		assert (bad_len == 0) else
			note_mismatch($sformatf("%0d hsync pulses not %0d long", bad_len, H_SYNC));
		assert (vs_low == V_SYNC * H_TOTAL) else
			note_mismatch($sformatf("vsync low for %0d cycles, expected %0d", vs_low,
				V_SYNC * H_TOTAL));
		assert (y + 1 == V_ACTIVE) else
			note_mismatch($sformatf("%0d visible lines, expected %0d", y + 1, V_ACTIVE));
		assert (bad_pix == 0) else
			note_mismatch($sformatf("%0d pixels differ from the glyph", bad_pix));
	endtask

	initial begin
		int          fd;
		int          got;
		int          load_errs;
		int          bad;
		int          rel_model;
		int          passed;
		int          failed;
		int          strobe_base;
		string       line;
		logic [7:0]  b;
		logic [7:0]  code;
		logic [7:0]  cnt;
		logic [63:0] glyph;
		logic        pending;
		logic        held_model;
		logic        err_seen;
		logic        ok;
		load_errs  = 0;
		rel_model  = 0;
		passed     = 0;
		failed     = 0;
		pending    = 1'b0;
		held_model = 1'b0;
		err_seen   = 1'b0;
		fd = $fopen("testbench/kbd_vga_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file");
			$display("TEST FAILED");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				got = $fgets(line, fd);
				if (got > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
					got = $sscanf(line, "%h %d %h %h %h", b, bad, code, cnt, glyph);
					if (got == 5) begin
						tr_byte.push_back(b);
						tr_bad.push_back(bad);
						tr_code.push_back(code);
						tr_count.push_back(cnt);
						tr_glyph.push_back(glyph);
					end else begin
						$display("trace line could not be read: %s", line);
						load_errs++;
					end
				end
			end
			$fclose(fd);
			n_steps = tr_byte.size();

			wait_cycles(5);
			rst <= 1'b0;

			for (int i = 0; i < n_steps; i++) begin
				step_errs = 0;
				wait_cycles($unsigned($random(seed)) % 4);
				strobe_base = strobes;
				send_frame(tr_byte[i], tr_bad[i]);

				// release counting, held key and the sticky error flag
				if (tr_bad[i] != 0) begin
					err_seen = 1'b1;
				end else if (pending) begin
					rel_model = (rel_model + 1) % 256;
					pending   = 1'b0;
				end else if (tr_byte[i] == 8'hF0) begin
					pending    = 1'b1;
					held_model = 1'b0;
				end else begin
					held_model = 1'b1;
				end

				wait_idle(ok);
				assert (ok) else begin
					$display("step %0d: receiver stayed busy after the frame", i);
					step_errs++;
				end
				@(negedge clk);
				assert (ledr[15:8] == tr_code[i]) else
					note_mismatch($sformatf("ledr code %h, expected %h", ledr[15:8], tr_code[i]));
				assert (seg0 == ~SEG_REF[tr_code[i][3:0]]) else
					note_mismatch($sformatf("seg0 %h for code %h", seg0, tr_code[i]));
				assert (seg1 == ~SEG_REF[tr_code[i][7:4]]) else
					note_mismatch($sformatf("seg1 %h for code %h", seg1, tr_code[i]));
				assert (seg4 == ~SEG_REF[rel_model % 16]) else
					note_mismatch($sformatf("seg4 %h for count %0d", seg4, rel_model));
				assert (seg5 == ~SEG_REF[rel_model / 16]) else
					note_mismatch($sformatf("seg5 %h for count %0d", seg5, rel_model));
				assert (tr_count[i] == 8'(rel_model)) else
					note_mismatch($sformatf("trace count %h, model %0d", tr_count[i], rel_model));
				assert (ledr[1] == err_seen) else
					note_mismatch($sformatf("error led %b, expected %b", ledr[1], err_seen));
				assert (ledr[7:3] == {4'b0000, held_model}) else
					note_mismatch($sformatf("ledr[7:3] %b, expected %b", ledr[7:3],
						{4'b0000, held_model}));
				assert (strobes - strobe_base == ((tr_bad[i] == 2) ? 0 : 1)) else
					note_mismatch($sformatf("%0d byte strobes for flag %0d",
						strobes - strobe_base, tr_bad[i]));
				check_frame(tr_glyph[i]);

				if (step_errs == 0) begin
					passed++;
				end else begin
					failed++;
				end
				$display("step %0d: byte %h flag %0d, %0d errors", i, tr_byte[i], tr_bad[i],
					step_errs);
			end

			$display("%0d steps: %0d passed, %0d failed, %0d bad trace lines", n_steps,
				passed, failed, load_errs);
			if (failed == 0 && load_errs == 0 && n_steps > 0) begin
				$display("TEST PASSED");
			end else begin
				$display("TEST FAILED");
			end
			$finish;
		end
	end

	// per step: one PS/2 frame with margin and up to two video frames
	initial begin
		int limit;
		wait (n_steps > 0);
		limit = n_steps * (12 * PS2_PERIOD + 2 * FRAME) + 2 * FRAME;
		#(limit * CLK_PERIOD);
		$display("watchdog expired after %0d cycles", limit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* testbench/kbd_vga_trace.txt */
# byte  flag(0 clean, 1 bad parity, 2 no stop bit)  key code  release count  glyph rows 0..7
# the glyph column is 16 hex digits, row 0 first, bit 7 of each row is the leftmost pixel
15 0 15 00 3C666666763C0E00
F0 0 15 00 3C666666763C0E00
15 0 00 01 0000000000000000
23 0 23 01 786C6666666C7800
1C 1 23 01 786C6666666C7800
1C 2 23 01 786C6666666C7800
F0 0 23 01 786C6666666C7800
23 0 00 02 0000000000000000
1C 0 1C 02 183C66667E666600
1B 0 1B 02 3C66603C06663C00
F0 1 1B 02 3C66603C06663C00
F0 0 1B 02 3C66603C06663C00
1B 0 00 03 0000000000000000
29 0 29 03 0000000000000000
F0 0 29 03 0000000000000000
29 0 00 04 0000000000000000
15 0 15 04 3C666666763C0E00
F0 0 15 04 3C666666763C0E00
44 0 00 05 0000000000000000

/* list.f */
rtl/kbd_pkg.sv
rtl/disp_pkg.sv
rtl/ps2_receiver.sv
rtl/key_event_fsm.sv
rtl/vga_timing.sv
rtl/glyph_renderer.sv
rtl/seg_display.sv
rtl/kbd_vga_top.sv
testbench/tb_clock.sv
testbench/kbd_vga_tb.sv

/* Makefile */
SIM   = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = kbd_vga_tb
FLIST = list.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
